// ==== tb.f ====
rtl/sdram_pkg.sv
rtl/bus_bridge_32_16.sv
rtl/sdram_controller.sv
rtl/sdram_subsystem.sv
tb/sdram_model.sv
tb/tb_sdram_subsystem.sv

// ==== tb/tb_sdram_subsystem.sv ====
`timescale 1ns/1ps

module tb_sdram_subsystem
	import sdram_pkg::*;
();

	typedef enum logic [2:0] {
		op_sdram_wr, op_sdram_rd, op_ctrl_rd, op_ctrl_wr, op_both, op_gap
	} op_e;

	typedef struct packed {
		op_e op;
		logic [29:0] addr;
		logic [31:0] data; // cycle count for a gap.
		logic [3:0] bytesel;
		logic [31:0] exp_data;
		logic exp_err;
	} entry_t;

	localparam int max_entries = 32;
	localparam int random_count = 40;
	localparam int ack_limit = 60;

	logic clk = 1'b0;
	logic reset;
	logic bus_access;
	logic sdram_cs;
	logic ctrl_cs;
	logic [29:0] bus_addr;
	logic [31:0] bus_wr_val;
	logic bus_wr_en;
	logic [3:0] bus_bytesel;
	logic bus_ack;
	logic bus_error;
	logic [31:0] bus_data;
	logic s_cs_n;
	logic s_ras_n;
	logic s_cas_n;
	logic s_wr_en;
	logic [1:0] s_bytesel;
	logic [12:0] s_addr;
	logic [1:0] s_banksel;
	logic s_clken;
	wire [15:0] s_data;

	entry_t stimulus [max_entries];
	int entry_count = 0;
	logic [22:0] ref_keys [$]; // the bridge only uses the low 23 word address bits.
	logic [31:0] ref_vals [$];
	int pass_count = 0;
	int fail_count = 0;
	int cycle_count = 0;
	int timeout_limit = 0;
	int seed = 32'hb197;

	sdram_subsystem u_sdram_subsystem (
		.clk(clk), .reset(reset), .bus_access(bus_access), .sdram_cs(sdram_cs),
		.ctrl_cs(ctrl_cs), .bus_addr(bus_addr), .bus_wr_val(bus_wr_val),
		.bus_wr_en(bus_wr_en), .bus_bytesel(bus_bytesel), .bus_ack(bus_ack),
		.bus_error(bus_error), .bus_data(bus_data), .s_cs_n(s_cs_n), .s_ras_n(s_ras_n),
		.s_cas_n(s_cas_n), .s_wr_en(s_wr_en), .s_bytesel(s_bytesel), .s_addr(s_addr),
		.s_banksel(s_banksel), .s_clken(s_clken), .s_data(s_data)
	);

	sdram_model u_sdram_model (
		.clk(clk), .cke(s_clken), .cs_n(s_cs_n), .ras_n(s_ras_n), .cas_n(s_cas_n),
		.we_n(s_wr_en), .dqm(s_bytesel), .addr(s_addr), .ba(s_banksel), .dq(s_data)
	);

	always #50 clk = ~clk;

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > timeout_limit) begin
			$display("Run stopped: still busy after %0d cycles", cycle_count);
			$display("Checks failed");
			$finish;
		end
	end

	function automatic logic [31:0] expected_word(input logic [29:0] addr);
		foreach (ref_keys[i])
			if (ref_keys[i] == addr[22:0])
				return ref_vals[i];
		return 32'h0;
	endfunction

	task automatic store_expected(input logic [29:0] addr, input logic [31:0] data,
			input logic [3:0] sel);
		logic [31:0] word;
		int idx;
		word = expected_word(addr);
		idx = -1;
		for (int b = 0; b < 4; b++)
			if (sel[b])
				word[8*b +: 8] = data[8*b +: 8];
		foreach (ref_keys[i])
			if (ref_keys[i] == addr[22:0])
				idx = i;
		if (idx < 0) begin
			ref_keys.push_back(addr[22:0]);
			ref_vals.push_back(word);
		end else begin
			ref_vals[idx] = word;
		end
	endtask

	task automatic add_entry(input op_e op, input logic [29:0] addr, input logic [31:0] data,
			input logic [3:0] sel, input logic [31:0] exp_data, input logic exp_err);
		stimulus[entry_count] = '{op, addr, data, sel, exp_data, exp_err};
		entry_count++;
	endtask

	// called on a falling edge; the request stays up through the acknowledge cycle,
	// then one idle cycle follows.
	task automatic drive_access(input entry_t e, output logic got_ack, output int cycles,
			output logic [31:0] rdata, output logic err, output logic late_ack);
		got_ack = 1'b0;
		cycles = 0;
		late_ack = 1'b0;
		bus_access = 1'b1;
		sdram_cs = (e.op == op_sdram_wr || e.op == op_sdram_rd || e.op == op_both);
		ctrl_cs = (e.op == op_ctrl_rd || e.op == op_ctrl_wr || e.op == op_both);
		bus_wr_en = (e.op == op_sdram_wr || e.op == op_ctrl_wr || e.op == op_both);
		bus_addr = e.addr;
		bus_wr_val = e.data;
		bus_bytesel = e.bytesel;
		while (!got_ack && cycles < ack_limit) begin
			@(negedge clk);
			cycles++;
			got_ack = bus_ack;
		end
		rdata = bus_data;
		err = bus_error;
		@(negedge clk);
		late_ack = got_ack && bus_ack; // the acknowledge must last one cycle only.
		bus_access = 1'b0;
		sdram_cs = 1'b0;
		ctrl_cs = 1'b0;
		bus_wr_en = 1'b0;
		@(negedge clk);
	endtask

	task automatic check_value(input int num, input string what, input logic [31:0] got,
			input logic [31:0] exp);
		assert (got === exp) pass_count++;
		else begin
			$display("Error at %0t: test %0d %s is 0x%h, expected 0x%h",
				$time, num, what, got, exp);
			fail_count++;
		end
	endtask

	task automatic apply_test(input int num, input entry_t e);
		logic got_ack;
		int cycles;
		logic [31:0] rdata;
		logic err;
		logic late_ack;
		logic [31:0] expected;
		int fails_before;
		fails_before = fail_count;
		if (e.op == op_gap) begin
			repeat (e.data) @(negedge clk);
			$display("test %0d idle gap of %0d cycles", num, e.data);
		end else begin
			expected = (e.op == op_sdram_rd) ? expected_word(e.addr) : e.exp_data;
			drive_access(e, got_ack, cycles, rdata, err, late_ack);
			assert (got_ack) pass_count++;
			else begin
				$display("Test %0d was never acknowledged within %0d cycles", num, ack_limit);
				fail_count++;
			end
			if (got_ack) begin
				check_value(num, "bus_error", 32'(err), 32'(e.exp_err));
				check_value(num, "bus_ack after its cycle", 32'(late_ack), 32'h0);
				if (e.op == op_sdram_rd || e.op == op_ctrl_rd)
					check_value(num, "bus_data", rdata, expected);
				if (e.op != op_sdram_wr && e.op != op_sdram_rd)
					check_value(num, "ack latency", cycles, 1);
				if (e.op == op_sdram_wr)
					store_expected(e.addr, e.data, e.bytesel);
			end
			$display("test %0d %s addr 0x%h %s", num, e.op.name(), e.addr,
				(fail_count == fails_before) ? "passed" : "failed");
		end
	endtask

	initial begin
		entry_t e;
		logic [31:0] r;
		reset = 1'b1;
		bus_access = 1'b0;
		sdram_cs = 1'b0;
		ctrl_cs = 1'b0;
		bus_addr = '0;
		bus_wr_val = '0;
		bus_wr_en = 1'b0;
		bus_bytesel = '0;

		add_entry(op_ctrl_rd, 30'h0, 32'h0, 4'hf, 32'h0, 1'b0); // still initialising.
		add_entry(op_gap, 30'h0, 32'd150, 4'h0, 32'h0, 1'b0);
		add_entry(op_ctrl_rd, 30'h0, 32'h0, 4'hf, 32'h1, 1'b0);
		add_entry(op_sdram_wr, 30'h000010, 32'h11223344, 4'hf, 32'h0, 1'b0);
		add_entry(op_sdram_wr, 30'h200123, 32'ha5a55a5a, 4'hf, 32'h0, 1'b0);
		add_entry(op_sdram_wr, 30'h4abcd5, 32'hdeadbeef, 4'hf, 32'h0, 1'b0);
		add_entry(op_sdram_wr, 30'h7fffff, 32'h0badf00d, 4'hf, 32'h0, 1'b0);
		add_entry(op_sdram_rd, 30'h000010, 32'h0, 4'hf, 32'h0, 1'b0);
		add_entry(op_sdram_rd, 30'h200123, 32'h0, 4'hf, 32'h0, 1'b0);
		add_entry(op_sdram_rd, 30'h4abcd5, 32'h0, 4'hf, 32'h0, 1'b0);
		add_entry(op_sdram_rd, 30'h7fffff, 32'h0, 4'hf, 32'h0, 1'b0);
		add_entry(op_sdram_wr, 30'h000010, 32'hffeeddcc, 4'b0101, 32'h0, 1'b0);
		add_entry(op_sdram_wr, 30'h200123, 32'h12345678, 4'b1000, 32'h0, 1'b0);
		add_entry(op_sdram_wr, 30'h4abcd5, 32'h9abcdef0, 4'b0110, 32'h0, 1'b0);
		add_entry(op_sdram_rd, 30'h000010, 32'h0, 4'hf, 32'h0, 1'b0);
		add_entry(op_sdram_rd, 30'h200123, 32'h0, 4'hf, 32'h0, 1'b0);
		add_entry(op_sdram_rd, 30'h4abcd5, 32'h0, 4'hf, 32'h0, 1'b0);
		add_entry(op_gap, 30'h0, 32'd900, 4'h0, 32'h0, 1'b0); // spans a refresh.
		add_entry(op_sdram_rd, 30'h000010, 32'h0, 4'hf, 32'h0, 1'b0);
		add_entry(op_sdram_rd, 30'h7fffff, 32'h0, 4'hf, 32'h0, 1'b0);
		add_entry(op_ctrl_wr, 30'h000010, 32'hcafef00d, 4'hf, 32'h0, 1'b1);
		add_entry(op_both, 30'h4abcd5, 32'h55555555, 4'hf, 32'h0, 1'b1);
		add_entry(op_sdram_rd, 30'h000010, 32'h0, 4'hf, 32'h0, 1'b0);
		add_entry(op_sdram_rd, 30'h4abcd5, 32'h0, 4'hf, 32'h0, 1'b0);
		add_entry(op_ctrl_rd, 30'h0, 32'h0, 4'hf, 32'h1, 1'b0);
		timeout_limit = init_wait_cycles + 60 * entry_count + 60 * random_count + 2000;

		repeat (2) @(negedge clk);
		reset = 1'b0;

		for (int i = 0; i < entry_count; i++)
			apply_test(i, stimulus[i]);

		// random traffic over sixteen words, so reads often hit earlier writes.
		for (int i = 0; i < random_count; i++) begin
			r = $random(seed);
			if (r[8])
				e.op = op_sdram_wr;
			else
				e.op = op_sdram_rd;
			e.addr = 30'h100 + r[3:0];
			e.data = $random(seed);
			e.bytesel = r[7:4];
			e.exp_data = '0;
			e.exp_err = 1'b0;
			apply_test(entry_count + i, e);
		end

		$display("summary: %0d passed, %0d failed", pass_count, fail_count);
		if (fail_count == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

// ==== tb/sdram_model.sv ====
`timescale 1ns/1ps

module sdram_model
	import sdram_pkg::*;
(
	input  logic                 clk,
	input  logic                 cke,
	input  logic                 cs_n,
	input  logic                 ras_n,
	input  logic                 cas_n,
	input  logic                 we_n,
	input  logic [1:0]           dqm,
	input  logic [row_bits-1:0]  addr,
	input  logic [bank_bits-1:0] ba,
	inout  wire  [15:0]          dq
);

	// sparse storage; a location that was never written reads as zero.
	logic [half_addr_bits-1:0] keys [$];
	logic [15:0] vals [$];
	logic [row_bits-1:0] open_row [1 << bank_bits];
	logic [cas_latency-1:0] rd_valid = '0;
	logic [15:0] rd_pipe [cas_latency];
	sdram_cmd_e cmd;
	logic [half_addr_bits-1:0] loc;

	assign cmd = sdram_cmd_e'({cs_n, ras_n, cas_n, we_n});
	assign loc = {ba, open_row[ba], addr[col_bits-1:0]};
	assign dq = rd_valid[cas_latency-1] ? rd_pipe[cas_latency-1] : 16'bz;

	function automatic int find_location(input logic [half_addr_bits-1:0] a);
		foreach (keys[i])
			if (keys[i] == a)
				return i;
		return -1;
	endfunction

	always @(posedge clk) begin
		int idx;
		logic [15:0] word;
		if (cke) begin
			rd_valid <= rd_valid << 1; // read data walks towards the pins.
			for (int i = 1; i < cas_latency; i++)
				rd_pipe[i] <= rd_pipe[i-1];
			case (cmd)
				cmd_active: open_row[ba] <= addr;
				cmd_read: begin
					idx = find_location(loc);
					rd_pipe[0] <= (idx < 0) ? 16'h0 : vals[idx];
					rd_valid[0] <= 1'b1;
				end
				cmd_write: begin
					idx = find_location(loc);
					word = (idx < 0) ? 16'h0 : vals[idx];
					if (!dqm[0])
						word[7:0] = dq[7:0];
					if (!dqm[1])
						word[15:8] = dq[15:8];
					if (idx < 0) begin
						keys.push_back(loc);
						vals.push_back(word);
					end else begin
						vals[idx] = word;
					end
				end
				default: ; // precharge, refresh and mode set leave the data alone.
			endcase
		end
	end

endmodule

// ==== rtl/sdram_subsystem.sv ====
`timescale 1ns/1ps

module sdram_subsystem (
	input  logic        clk,
	input  logic        reset,
	input  logic        bus_access,
	input  logic        sdram_cs,
	input  logic        ctrl_cs,
	input  logic [29:0] bus_addr,
	input  logic [31:0] bus_wr_val,
	input  logic        bus_wr_en,
	input  logic [3:0]  bus_bytesel,
	output logic        bus_ack,
	output logic        bus_error,
	output logic [31:0] bus_data,
	output logic        s_cs_n,
	output logic        s_ras_n,
	output logic        s_cas_n,
	output logic        s_wr_en,
	output logic [1:0]  s_bytesel,
	output logic [12:0] s_addr,
	output logic [1:0]  s_banksel,
	output logic        s_clken,
	inout  wire  [15:0] s_data
);

	logic sdram_access;
	logic ctrl_read;
	logic illegal;
	logic ctrl_ack;
	logic [31:0] ctrl_data;
	logic config_done;
	logic sdram_ack;
	logic [31:0] sdram_data;
	logic [23:0] bridge_addr;
	logic [15:0] bridge_wdata;
	logic [15:0] bridge_rdata;
	logic bridge_wr_en;
	logic [1:0] bridge_bytesel;
	logic bridge_req;
	logic bridge_compl;

	// both selects at once, or any write to the control register, is refused.
	assign illegal = bus_access && ctrl_cs && (sdram_cs || bus_wr_en);
	assign sdram_access = bus_access && sdram_cs && !ctrl_cs;
	assign ctrl_read = bus_access && ctrl_cs && !sdram_cs && !bus_wr_en;

	assign bus_ack = sdram_ack | ctrl_ack;
	assign bus_data = sdram_ack ? sdram_data : ctrl_data;

	always_ff @(posedge clk) begin
		if (reset) begin
			ctrl_ack <= 1'b0;
			bus_error <= 1'b0;
		end else begin
			// the host still holds the access in the ack cycle, so skip it there.
			ctrl_ack <= (ctrl_read || illegal) && !ctrl_ack;
			bus_error <= illegal && !ctrl_ack;
		end
	end

	always_ff @(posedge clk) begin
		if (ctrl_read)
			ctrl_data <= {31'b0, config_done};
		else
			ctrl_data <= '0;
	end

	bus_bridge_32_16 u_bridge (
		.clk       (clk),
		.reset     (reset),
		.h_cs      (sdram_access),
		.h_addr    (bus_addr),
		.h_wdata   (bus_wr_val),
		.h_wr_en   (bus_wr_en),
		.h_bytesel (bus_bytesel),
		.h_rdata   (sdram_data),
		.h_compl   (sdram_ack),
		.b_rdata   (bridge_rdata),
		.b_compl   (bridge_compl),
		.b_addr    (bridge_addr),
		.b_wdata   (bridge_wdata),
		.b_wr_en   (bridge_wr_en),
		.b_bytesel (bridge_bytesel),
		.b_req     (bridge_req)
	);

	sdram_controller u_controller (
		.clk         (clk),
		.reset       (reset),
		.b_req       (bridge_req),
		.b_addr      (bridge_addr),
		.b_wdata     (bridge_wdata),
		.b_wr_en     (bridge_wr_en),
		.b_bytesel   (bridge_bytesel),
		.b_rdata     (bridge_rdata),
		.b_compl     (bridge_compl),
		.config_done (config_done),
		.s_cs_n      (s_cs_n),
		.s_ras_n     (s_ras_n),
		.s_cas_n     (s_cas_n),
		.s_wr_en     (s_wr_en),
		.s_bytesel   (s_bytesel),
		.s_addr      (s_addr),
		.s_banksel   (s_banksel),
		.s_clken     (s_clken),
		.s_data      (s_data)
	);

endmodule

// ==== rtl/sdram_controller.sv ====
`timescale 1ns/1ps

module sdram_controller
	import sdram_pkg::*;
(
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      b_req,
	input  logic [half_addr_bits-1:0] b_addr,
	input  logic [15:0]               b_wdata,
	input  logic                      b_wr_en,
	input  logic [1:0]                b_bytesel,
	output logic [15:0]               b_rdata,
	output logic                      b_compl,
	output logic                      config_done,
	output logic                      s_cs_n,
	output logic                      s_ras_n,
	output logic                      s_cas_n,
	output logic                      s_wr_en,
	output logic [1:0]                s_bytesel,
	output logic [row_bits-1:0]       s_addr,
	output logic [bank_bits-1:0]      s_banksel,
	output logic                      s_clken,
	inout  wire  [15:0]               s_data
);

	ctrl_state_e state;
	sdram_cmd_e cmd;
	logic [row_bits-1:0] addr_q;
	logic [bank_bits-1:0] bank_q;
	logic [1:0] dqm_q;
	logic [15:0] wdata_q;
	logic drive_q;
	logic [wait_bits-1:0] wait_cnt;
	logic [refresh_bits-1:0] refresh_timer;
	logic refresh_pending;
	logic second_refresh;
	logic [bank_bits-1:0] req_bank;
	logic [row_bits-1:0] req_row;
	logic [col_bits-1:0] req_col;

	assign req_bank = b_addr[half_addr_bits-1 -: bank_bits];
	assign req_row = b_addr[col_bits +: row_bits];
	assign req_col = b_addr[col_bits-1:0];

	assign {s_cs_n, s_ras_n, s_cas_n, s_wr_en} = cmd;
	assign s_addr = addr_q;
	assign s_banksel = bank_q;
	assign s_bytesel = dqm_q;
	assign s_clken = 1'b1;
	assign s_data = drive_q ? wdata_q : 16'bz;

	// every refresh_interval cycles a refresh is owed until idle serves it.
	always_ff @(posedge clk) begin
		if (reset) begin
			refresh_timer <= '0;
			refresh_pending <= 1'b0;
		end else begin
			if (state == st_idle && refresh_pending)
				refresh_pending <= 1'b0;
			if (refresh_timer == refresh_bits'(refresh_interval - 1)) begin
				refresh_timer <= '0;
				refresh_pending <= 1'b1;
			end else begin
				refresh_timer <= refresh_timer + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= st_init_wait;
			wait_cnt <= wait_bits'(init_wait_cycles - 1);
			cmd <= cmd_nop;
			addr_q <= '0;
			bank_q <= '0;
			dqm_q <= '0;
			drive_q <= 1'b0;
			second_refresh <= 1'b0;
			config_done <= 1'b0;
			b_compl <= 1'b0;
		end else begin
			cmd <= cmd_nop; // every command lasts a single cycle.
			dqm_q <= '0;
			drive_q <= 1'b0;
			b_compl <= 1'b0;
			if (wait_cnt != '0)
				wait_cnt <= wait_cnt - 1'b1;

			case (state)
				st_init_wait: if (wait_cnt == '0) begin
					cmd <= cmd_precharge;
					addr_q <= auto_precharge; // precharge all banks.
					wait_cnt <= wait_bits'(t_rp_cycles - 1);
					state <= st_init_precharge;
				end
				st_init_precharge: if (wait_cnt == '0) begin
					cmd <= cmd_refresh;
					wait_cnt <= wait_bits'(t_rfc_cycles - 1);
					state <= st_init_refresh;
				end
				st_init_refresh: if (wait_cnt == '0) begin
					if (!second_refresh) begin
						cmd <= cmd_refresh;
						second_refresh <= 1'b1;
						wait_cnt <= wait_bits'(t_rfc_cycles - 1);
					end else begin
						cmd <= cmd_load_mode;
						addr_q <= mode_word;
						bank_q <= '0;
						wait_cnt <= wait_bits'(1);
						state <= st_init_mode;
					end
				end
				st_init_mode: if (wait_cnt == '0) begin
					config_done <= 1'b1;
					state <= st_idle;
				end
				st_idle: begin
					if (refresh_pending) begin
						cmd <= cmd_refresh;
						wait_cnt <= wait_bits'(t_rfc_cycles - 1);
						state <= st_refresh;
					end else if (b_req) begin
						cmd <= cmd_active;
						addr_q <= req_row;
						bank_q <= req_bank;
						wait_cnt <= wait_bits'(t_rcd_cycles - 1);
						state <= st_activate;
					end
				end
				st_refresh: if (wait_cnt == '0) begin
					state <= st_idle;
				end
				st_activate: if (wait_cnt == '0) begin
					addr_q <= auto_precharge | row_bits'(req_col);
					if (b_wr_en) begin
						cmd <= cmd_write;
						dqm_q <= ~b_bytesel; // dqm high masks the lane.
						drive_q <= 1'b1;
						wait_cnt <= wait_bits'(t_rp_cycles - 1);
					end else begin
						cmd <= cmd_read;
						wait_cnt <= wait_bits'(cas_latency - 1);
					end
					state <= st_rw;
				end
				st_rw: if (wait_cnt == '0) begin
					if (b_wr_en) begin
						b_compl <= 1'b1;
						state <= st_done;
					end else begin
						state <= st_read_wait;
					end
				end
				st_read_wait: begin
					b_compl <= 1'b1; // data is captured on this edge.
					state <= st_done;
				end
				default: begin
					state <= st_idle;
				end
			endcase
		end
	end

	// write data goes out with the write command.
	always_ff @(posedge clk) begin
		if (state == st_activate && wait_cnt == '0)
			wdata_q <= b_wdata;
	end

	always_ff @(posedge clk) begin
		if (state == st_read_wait)
			b_rdata <= s_data;
	end

endmodule

// ==== rtl/bus_bridge_32_16.sv ====
`timescale 1ns/1ps

module bus_bridge_32_16
	import sdram_pkg::*;
(
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      h_cs,
	input  logic [29:0]               h_addr,
	input  logic [31:0]               h_wdata,
	input  logic                      h_wr_en,
	input  logic [3:0]                h_bytesel,
	output logic [31:0]               h_rdata,
	output logic                      h_compl,
	input  logic [15:0]               b_rdata,
	input  logic                      b_compl,
	output logic [half_addr_bits-1:0] b_addr,
	output logic [15:0]               b_wdata,
	output logic                      b_wr_en,
	output logic [1:0]                b_bytesel,
	output logic                      b_req
);

	typedef enum logic [1:0] {
		br_low,
		br_high,
		br_finish
	} br_state_e;

	br_state_e state;
	logic high_half;
	logic [15:0] rdata_lo;

	assign high_half = (state == br_high);

	// the word address becomes a halfword address with the half select as its lsb.
	assign b_addr = {h_addr[half_addr_bits-2:0], high_half};
	assign b_wdata = high_half ? h_wdata[31:16] : h_wdata[15:0];
	assign b_bytesel = high_half ? h_bytesel[3:2] : h_bytesel[1:0];
	assign b_wr_en = h_wr_en;
	assign b_req = h_cs && (state != br_finish); // quiet while the word completes.

	// the controller keeps its read register until the next read.
	assign h_rdata = {b_rdata, rdata_lo};

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= br_low;
			h_compl <= 1'b0;
		end else begin
			h_compl <= 1'b0;
			case (state)
				br_low: begin
					if (b_compl)
						state <= br_high;
				end
				br_high: begin
					if (b_compl) begin
						state <= br_finish;
						h_compl <= 1'b1;
					end
				end
				default: begin
					state <= br_low;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == br_low && b_compl)
			rdata_lo <= b_rdata;
	end

endmodule

// ==== rtl/sdram_pkg.sv ====
package sdram_pkg;

	// device geometry. A halfword address is {bank, row, column}.
	localparam int row_bits = 13;
	localparam int col_bits = 9;
	localparam int bank_bits = 2;
	localparam int half_addr_bits = bank_bits + row_bits + col_bits;

	// timing in clock cycles.
	localparam int t_rcd_cycles = 2;
	localparam int t_rp_cycles = 2;
	localparam int t_rfc_cycles = 7;
	localparam int cas_latency = 2;
	localparam int init_wait_cycles = 100; // much shorter than a real part needs.
	localparam int refresh_interval = 780;

	localparam int wait_bits = $clog2(init_wait_cycles);
	localparam int refresh_bits = $clog2(refresh_interval);

	// burst length 1, sequential, cas latency 2, single location writes.
	localparam logic [row_bits-1:0] mode_word = 13'h0220;
	localparam logic [row_bits-1:0] auto_precharge = 13'h0400; // a10 high.

	// encoded as {cs_n, ras_n, cas_n, we_n}.
	typedef enum logic [3:0] {
		cmd_nop       = 4'b0111,
		cmd_active    = 4'b0011,
		cmd_read      = 4'b0101,
		cmd_write     = 4'b0100,
		cmd_precharge = 4'b0010,
		cmd_refresh   = 4'b0001,
		cmd_load_mode = 4'b0000
	} sdram_cmd_e;

	typedef enum logic [3:0] {
		st_init_wait, st_init_precharge, st_init_refresh, st_init_mode,
		st_idle, st_refresh, st_activate, st_rw, st_read_wait, st_done
	} ctrl_state_e;

endpackage
